//--- hw/afu_pkg.sv
`default_nettype none

package afu_pkg;

    // ============================================================
    // Sizes
    // ============================================================

    // Both copy engines form a single group
    localparam int num_engines = 2;

    // MMIO word index, split into a window and an offset
    localparam int mmio_addr_w = 8;
    localparam int csr_off_w = 3;
    localparam int csr_win_w = mmio_addr_w - csr_off_w;

    // Host addresses count 64-bit lines, not bytes
    localparam int host_addr_w = 32;
    localparam int data_w = 64;

    // Line count and all engine counters share one width
    localparam int count_w = 16;

    // Identifier that software reads to recognize this test
    localparam logic [127:0] afu_test_id =
        128'h7d3a_91c4_2e6f_4b08_a5d1_c03e_98f2_6b17;

    // ============================================================
    // Register map
    // ============================================================

    // Window 0 is global and window e+1 belongs to engine e
    localparam logic [csr_win_w-1:0] csr_win_global = '0;

    // Offsets inside an engine window
    localparam logic [csr_off_w-1:0] csr_src_addr    = 3'd0;
    localparam logic [csr_off_w-1:0] csr_dst_addr    = 3'd1;
    localparam logic [csr_off_w-1:0] csr_num_lines   = 3'd2;
    localparam logic [csr_off_w-1:0] csr_start       = 3'd3;
    localparam logic [csr_off_w-1:0] csr_status      = 3'd4;
    localparam logic [csr_off_w-1:0] csr_reads_done  = 3'd5;
    localparam logic [csr_off_w-1:0] csr_writes_done = 3'd6;
    localparam logic [csr_off_w-1:0] csr_checksum    = 3'd7;

    // ============================================================
    // Port bundles
    // ============================================================

    // At most one strobe is high in a cycle
    typedef struct packed {
        logic                   wr;
        logic                   rd;
        logic [mmio_addr_w-1:0] addr;
        logic [data_w-1:0]      wr_data;
    } mmio_req_t;

    typedef struct packed {
        logic              valid;
        logic [data_w-1:0] data;
    } mmio_rsp_t;

    // The start strobe lasts a single cycle
    typedef struct packed {
        logic [host_addr_w-1:0] src_addr;
        logic [host_addr_w-1:0] dst_addr;
        logic [count_w-1:0]     num_lines;
        logic                   start;
    } eng_cfg_t;

    typedef struct packed {
        logic               active;
        logic [count_w-1:0] reads_done;
        logic [count_w-1:0] writes_done;
        logic [data_w-1:0]  checksum;
    } eng_status_t;

    // Read and write channels are independent and may fire together
    typedef struct packed {
        logic                   rd;
        logic [host_addr_w-1:0] rd_addr;
        logic                   wr;
        logic [host_addr_w-1:0] wr_addr;
        logic [data_w-1:0]      wr_data;
    } host_req_t;

    typedef struct packed {
        logic              rd_valid;
        logic [data_w-1:0] rd_data;
    } host_rsp_t;

endpackage

`default_nettype wire

//--- hw/csr_mgr.sv
`default_nettype none

module csr_mgr
    import afu_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  mmio_req_t   mmio_req,
    output mmio_rsp_t   mmio_rsp,
    input  eng_status_t eng_status [num_engines],
    output eng_cfg_t    eng_cfg [num_engines]
);

    // Window and offset of the current MMIO access
    logic [csr_win_w-1:0] win;
    logic [csr_off_w-1:0] off;

    // Stored configuration, start strobe included
    eng_cfg_t cfg_q [num_engines];

    // Read path
    logic [data_w-1:0] rd_data;
    logic              rsp_valid_q;
    logic [data_w-1:0] rsp_data_q;

    // The upper bits pick the window and the lower bits the register
    assign win = mmio_req.addr[mmio_addr_w-1:csr_off_w];
    assign off = mmio_req.addr[csr_off_w-1:0];

    // ============================================================
    // Configuration writes
    // ============================================================

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            for (int e = 0; e < num_engines; e++)
            begin
                cfg_q[e] <= '0;
            end
        end
        else
        begin
            for (int e = 0; e < num_engines; e++)
            begin
                // Start is a strobe, so it drops again unless rewritten
                cfg_q[e].start <= 1'b0;

                if (mmio_req.wr && (win == csr_win_w'(e + 1)))
                begin
                    case (off)
                        csr_src_addr:
                            cfg_q[e].src_addr <= mmio_req.wr_data[host_addr_w-1:0];
                        csr_dst_addr:
                            cfg_q[e].dst_addr <= mmio_req.wr_data[host_addr_w-1:0];
                        csr_num_lines:
                            cfg_q[e].num_lines <= mmio_req.wr_data[count_w-1:0];
                        // The written value is ignored, only the access counts
                        csr_start:
                            cfg_q[e].start <= 1'b1;
                        default:
                        begin
                            // Status registers are read only
                        end
                    endcase
                end
            end
        end
    end

    assign eng_cfg = cfg_q;

    // ============================================================
    // Read multiplexer
    // ============================================================

    always_comb
    begin
        rd_data = '0;

        if (win == csr_win_global)
        begin
            case (off)
                // Identifier halves, low word first
                3'd0: rd_data = afu_test_id[63:0];
                3'd1: rd_data = afu_test_id[127:64];
                // Engine count sits in the low byte
                3'd2: rd_data = data_w'(8'(num_engines));
                default: rd_data = '0;
            endcase
        end

        // Windows above the last engine match nothing and read zero
        for (int e = 0; e < num_engines; e++)
        begin
            if (win == csr_win_w'(e + 1))
            begin
                case (off)
                    csr_src_addr:    rd_data = data_w'(cfg_q[e].src_addr);
                    csr_dst_addr:    rd_data = data_w'(cfg_q[e].dst_addr);
                    csr_num_lines:   rd_data = data_w'(cfg_q[e].num_lines);
                    csr_status:      rd_data = data_w'(eng_status[e].active);
                    csr_reads_done:  rd_data = data_w'(eng_status[e].reads_done);
                    csr_writes_done: rd_data = data_w'(eng_status[e].writes_done);
                    csr_checksum:    rd_data = eng_status[e].checksum;
                    // The start register has no stored value
                    default:         rd_data = '0;
                endcase
            end
        end
    end

    // Response valid follows the read strobe by exactly one cycle
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            rsp_valid_q <= 1'b0;
        end
        else
        begin
            rsp_valid_q <= mmio_req.rd;
        end
    end

    // Data is only meaningful alongside the valid flag
    always_ff @(posedge clk)
    begin
        rsp_data_q <= rd_data;
    end

    always_comb
    begin
        mmio_rsp.valid = rsp_valid_q;
        mmio_rsp.data  = rsp_data_q;
    end

endmodule

`default_nettype wire

//--- hw/host_mem_rdwr_engine.sv
`default_nettype none

module host_mem_rdwr_engine
    import afu_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  eng_cfg_t    cfg,
    output eng_status_t status,
    output host_req_t   host_req,
    input  host_rsp_t   host_rsp
);

    // ============================================================
    // Job state
    // ============================================================

    logic active_q;

    // Job parameters captured at start so software may reprogram early
    logic [host_addr_w-1:0] src_q;
    logic [host_addr_w-1:0] dst_q;
    logic [count_w-1:0]     num_q;

    // Reads issued so far, any number of them may still be in flight
    logic [count_w-1:0] issue_cnt_q;

    // Responses seen so far, which doubles as the index of the next one
    logic [count_w-1:0] reads_done_q;
    logic [count_w-1:0] writes_done_q;
    logic [data_w-1:0]  checksum_q;

    // Registered write channel
    logic                   wr_q;
    logic [host_addr_w-1:0] wr_addr_q;
    logic [data_w-1:0]      wr_data_q;

    logic start_ok;
    logic rd_issue;
    logic rsp_take;
    logic last_write;

    // A start while busy is dropped
    assign start_ok = cfg.start && !active_q;

    // One read per cycle until every line has been requested
    assign rd_issue = active_q && (issue_cnt_q != num_q);

    // Stray responses outside a job are not counted
    assign rsp_take = active_q && host_rsp.rd_valid;

    // The write that completes the job
    assign last_write = wr_q && ((writes_done_q + count_w'(1)) == num_q);

    // ============================================================
    // Control and counters
    // ============================================================

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            active_q      <= 1'b0;
            issue_cnt_q   <= '0;
            reads_done_q  <= '0;
            writes_done_q <= '0;
            checksum_q    <= '0;
            wr_q          <= 1'b0;
        end
        else if (start_ok)
        begin
            // Counters restart even for an empty job, which never goes active
            active_q      <= (cfg.num_lines != '0);
            issue_cnt_q   <= '0;
            reads_done_q  <= '0;
            writes_done_q <= '0;
            checksum_q    <= '0;
            wr_q          <= 1'b0;
        end
        else
        begin
            if (rd_issue)
            begin
                issue_cnt_q <= issue_cnt_q + count_w'(1);
            end

            // Each response turns into a write on the next cycle
            wr_q <= rsp_take;
            if (rsp_take)
            begin
                reads_done_q <= reads_done_q + count_w'(1);
                checksum_q   <= checksum_q ^ host_rsp.rd_data;
            end

            if (wr_q)
            begin
                writes_done_q <= writes_done_q + count_w'(1);
            end

            // Active drops on the cycle after the final write
            if (last_write)
            begin
                active_q <= 1'b0;
            end
        end
    end

    // ============================================================
    // Payload registers
    // ============================================================

    always_ff @(posedge clk)
    begin
        if (start_ok)
        begin
            src_q <= cfg.src_addr;
            dst_q <= cfg.dst_addr;
            num_q <= cfg.num_lines;
        end

        // Responses return in order, so the count so far is the line index
        if (rsp_take)
        begin
            wr_addr_q <= dst_q + host_addr_w'(reads_done_q);
            wr_data_q <= host_rsp.rd_data;
        end
    end

    // ============================================================
    // Outputs
    // ============================================================

    always_comb
    begin
        host_req.rd      = rd_issue;
        host_req.rd_addr = src_q + host_addr_w'(issue_cnt_q);
        host_req.wr      = wr_q;
        host_req.wr_addr = wr_addr_q;
        host_req.wr_data = wr_data_q;
    end

    always_comb
    begin
        status.active      = active_q;
        status.reads_done  = reads_done_q;
        status.writes_done = writes_done_q;
        status.checksum    = checksum_q;
    end

endmodule

`default_nettype wire

//--- hw/afu_top.sv
`default_nettype none

module afu_top
    import afu_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  mmio_req_t mmio_req,
    output mmio_rsp_t mmio_rsp,
    output host_req_t host_req [num_engines],
    input  host_rsp_t host_rsp [num_engines]
);

    // Configuration flows from the register block to the engines
    eng_cfg_t eng_cfg [num_engines];

    // Status flows back for software to read
    eng_status_t eng_status [num_engines];

    // ============================================================
    // Register block
    // ============================================================

    // Answers every MMIO access, so the host never waits
    csr_mgr csr_mgr_i
    (
        .clk        (clk),
        .rst_n      (rst_n),
        .mmio_req   (mmio_req),
        .mmio_rsp   (mmio_rsp),
        .eng_status (eng_status),
        .eng_cfg    (eng_cfg)
    );

    // ============================================================
    // Copy engines
    // ============================================================

    // Engine e owns host port e and MMIO window e+1
    for (genvar e = 0; e < num_engines; e++)
    begin : g_eng
        host_mem_rdwr_engine eng_i
        (
            .clk      (clk),
            .rst_n    (rst_n),
            .cfg      (eng_cfg[e]),
            .status   (eng_status[e]),
            .host_req (host_req[e]),
            .host_rsp (host_rsp[e])
        );
    end

endmodule

`default_nettype wire

//--- sim/host_mem_model.sv
`default_nettype none

module host_mem_model
    import afu_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic [7:0] port_id,
    input  logic [1:0] rand_lat,
    input  host_req_t  host_req,
    output host_rsp_t  host_rsp
);

    timeunit 1ns;
    timeprecision 1ps;

    // Sparse storage, a line that was never written reads the fill pattern
    logic [data_w-1:0] mem [logic [host_addr_w-1:0]];

    // Reads waiting for their response cycle, oldest first
    logic [host_addr_w-1:0] pend_addr [$];
    longint                 pend_due [$];

    longint cycle_q = 0;
    longint last_due = 0;
    longint due;

    logic              rsp_valid_q = 1'b0;
    logic [data_w-1:0] rsp_data_q = '0;

    // Every bit of the address and the port number shows up in the word
    function automatic logic [data_w-1:0] fill_word(logic [host_addr_w-1:0] addr);
        return {addr ^ 32'h5ac3_0000 ^ 32'(port_id), addr * 32'h9e37_79b9};
    endfunction

    always @(posedge clk)
    begin
        rsp_valid_q <= 1'b0;
        cycle_q = cycle_q + 1;
        if (!rst_n)
        begin
            pend_addr.delete();
            pend_due.delete();
            last_due = cycle_q;
        end
        else
        begin
            // Writes land at once, so a later read returns the new line
            if (host_req.wr)
            begin
                mem[host_req.wr_addr] = host_req.wr_data;
            end

            // Latency of 1 to 4 cycles, never overtaking an older read
            if (host_req.rd)
            begin
                due = cycle_q + longint'(rand_lat) + 1;
                if (due <= last_due)
                begin
                    due = last_due + 1;
                end
                pend_addr.push_back(host_req.rd_addr);
                pend_due.push_back(due);
                last_due = due;
            end

            if (pend_due.size() != 0 && pend_due[0] == cycle_q)
            begin
                rsp_valid_q <= 1'b1;
                rsp_data_q  <= mem.exists(pend_addr[0]) ? mem[pend_addr[0]]
                                                        : fill_word(pend_addr[0]);
                void'(pend_addr.pop_front());
                void'(pend_due.pop_front());
            end
        end
    end

    always_comb
    begin
        host_rsp.rd_valid = rsp_valid_q;
        host_rsp.rd_data  = rsp_data_q;
    end

endmodule

`default_nettype wire

//--- sim/afu_tb.sv
`default_nettype none

module afu_tb
    import afu_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    // Pair rows start this engine and the next row's engine back to back
    typedef enum logic [1:0] {job_single, job_pair, job_restart} job_kind_t;

    typedef struct packed {
        job_kind_t              kind;
        logic [0:0]             eng;
        logic [host_addr_w-1:0] src;
        logic [host_addr_w-1:0] dst;
        logic [count_w-1:0]     lines;
    } job_t;

    // Source regions never overlap any destination
    job_t jobs [8] = '{
        '{job_single,  1'b0, 32'h0000_1000, 32'h0008_0000, 16'd1},
        '{job_single,  1'b0, 32'h0000_1100, 32'h0008_1000, 16'd17},
        '{job_single,  1'b1, 32'h0000_2000, 32'h0009_0000, 16'd9},
        '{job_single,  1'b1, 32'hffff_fff8, 32'h7fff_0000, 16'd8},
        '{job_pair,    1'b0, 32'h0000_3000, 32'h0008_2000, 16'd16},
        '{job_pair,    1'b1, 32'h0000_4000, 32'h0009_1000, 16'd20},
        '{job_restart, 1'b1, 32'h0000_5000, 32'h0009_2000, 16'd20},
        '{job_single,  1'b0, 32'h0000_6000, 32'h0008_3000, 16'd0}
    };

    logic      clk = 1'b0;
    logic      rst_n;
    mmio_req_t mmio_req;
    mmio_rsp_t mmio_rsp;
    host_req_t host_req [num_engines];
    host_rsp_t host_rsp [num_engines];

    logic [15:0] lfsr_q = 16'd58036;
    logic [1:0]  rand_lat [num_engines] = '{default: '0};

    // Strobes seen on each host port, and where each job began in them
    logic [host_addr_w-1:0] rd_addr_log [num_engines][$];
    logic [host_addr_w-1:0] wr_addr_log [num_engines][$];
    logic [data_w-1:0]      wr_data_log [num_engines][$];
    int                     base_rd [num_engines];
    int                     base_wr [num_engines];

    always #10 clk = ~clk;

    afu_top DUT
    (
        .clk      (clk),
        .rst_n    (rst_n),
        .mmio_req (mmio_req),
        .mmio_rsp (mmio_rsp),
        .host_req (host_req),
        .host_rsp (host_rsp)
    );

    for (genvar e = 0; e < num_engines; e++)
    begin : g_mem
        host_mem_model mem_i
        (
            .clk      (clk),
            .rst_n    (rst_n),
            .port_id  (8'(e)),
            .rand_lat (rand_lat[e]),
            .host_req (host_req[e]),
            .host_rsp (host_rsp[e])
        );
    end

    // ============================================================
    // Random latency and port monitors
    // ============================================================

    // 16-bit Galois LFSR with a maximal length tap mask
    function automatic logic [15:0] lfsr_next(logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    // Two fresh bits per port and cycle, one LFSR step per bit
    always @(negedge clk)
    begin
        for (int p = 0; p < num_engines; p++)
        begin
            for (int b = 0; b < 2; b++)
            begin
                rand_lat[p][b] = lfsr_q[0];
                lfsr_q = lfsr_next(lfsr_q);
            end
        end
    end

    // Outputs only move on the rising edge, so the falling edge sees them settled
    always @(negedge clk)
    begin
        for (int e = 0; e < num_engines; e++)
        begin
            if (host_req[e].rd === 1'b1)
            begin
                rd_addr_log[e].push_back(host_req[e].rd_addr);
            end
            if (host_req[e].wr === 1'b1)
            begin
                wr_addr_log[e].push_back(host_req[e].wr_addr);
                wr_data_log[e].push_back(host_req[e].wr_data);
            end
        end
    end

    // Same line contents as the memory model holds for unwritten lines
    function automatic logic [data_w-1:0] fill_word(int port, logic [host_addr_w-1:0] addr);
        return {addr ^ 32'h5ac3_0000 ^ 32'(port), addr * 32'h9e37_79b9};
    endfunction

    // ============================================================
    // Failure reporting and compare tasks
    // ============================================================

    task automatic abort_run(string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic compare_data(string name, logic [data_w-1:0] exp, logic [data_w-1:0] act);
        if (act !== exp)
        begin
            abort_run($sformatf("FAIL time=%0t %s expected=%h actual=%h",
                                $time, name, exp, act));
        end
    endtask

    task automatic compare_count(string name, logic [count_w-1:0] exp,
                                 logic [count_w-1:0] act);
        if (act !== exp)
        begin
            abort_run($sformatf("FAIL time=%0t %s expected=%0d actual=%0d",
                                $time, name, exp, act));
        end
    endtask

    task automatic compare_addr(string name, logic [host_addr_w-1:0] exp,
                                logic [host_addr_w-1:0] act);
        if (act !== exp)
        begin
            abort_run($sformatf("FAIL time=%0t %s expected=%h actual=%h",
                                $time, name, exp, act));
        end
    endtask

    task automatic compare_status(string name, eng_status_t exp, eng_status_t act);
        if (act !== exp)
        begin
            abort_run($sformatf("FAIL time=%0t %s expected=%h actual=%h",
                                $time, name, exp, act));
        end
    endtask

    // ============================================================
    // MMIO access
    // ============================================================

    task automatic mmio_write(int win, int off, logic [data_w-1:0] data);
        @(negedge clk);
        mmio_req.wr      = 1'b1;
        mmio_req.addr    = mmio_addr_w'((win << csr_off_w) + off);
        mmio_req.wr_data = data;
        @(negedge clk);
        mmio_req.wr = 1'b0;
    endtask

    task automatic mmio_read(int win, int off, output logic [data_w-1:0] data);
        int n;
        @(negedge clk);
        mmio_req.rd   = 1'b1;
        mmio_req.addr = mmio_addr_w'((win << csr_off_w) + off);
        @(negedge clk);
        mmio_req.rd = 1'b0;
        for (n = 0; n < 8 && !mmio_rsp.valid; n++)
        begin
            @(negedge clk);
        end
        if (!mmio_rsp.valid)
        begin
            abort_run($sformatf("MMIO read of window %0d offset %0d got no response", win, off));
        end
        data = mmio_rsp.data;
    endtask

    // Status lives at offsets 4 to 7 of the engine window
    task automatic read_status(int e, output eng_status_t st);
        logic [data_w-1:0] d;
        mmio_read(e + 1, int'(csr_status), d);
        st.active = d[0];
        mmio_read(e + 1, int'(csr_reads_done), d);
        st.reads_done = d[count_w-1:0];
        mmio_read(e + 1, int'(csr_writes_done), d);
        st.writes_done = d[count_w-1:0];
        mmio_read(e + 1, int'(csr_checksum), d);
        st.checksum = d;
    endtask

    task automatic wait_idle(int e);
        logic [data_w-1:0] d;
        int                polls;
        polls = 0;
        mmio_read(e + 1, int'(csr_status), d);
        while (d[0] && polls < 200)
        begin
            polls++;
            mmio_read(e + 1, int'(csr_status), d);
        end
        if (d[0])
        begin
            abort_run($sformatf("Engine %0d still active after %0d status polls, job hangs",
                                e, polls));
        end
    endtask

    // ============================================================
    // Job handling
    // ============================================================

    task automatic program_job(job_t j);
        mmio_write(int'(j.eng) + 1, int'(csr_src_addr), data_w'(j.src));
        mmio_write(int'(j.eng) + 1, int'(csr_dst_addr), data_w'(j.dst));
        mmio_write(int'(j.eng) + 1, int'(csr_num_lines), data_w'(j.lines));
        base_rd[j.eng] = rd_addr_log[j.eng].size();
        base_wr[j.eng] = wr_addr_log[j.eng].size();
    endtask

    // Reads and writes must arrive in order, one per line, each write a copy of its source line
    task automatic check_job(job_t j);
        int                e;
        logic [data_w-1:0] sum;
        logic [data_w-1:0] word;
        eng_status_t       exp_st;
        eng_status_t       act_st;
        e = int'(j.eng);
        sum = '0;
        compare_count($sformatf("host_req[%0d].rd strobes", e), j.lines,
                      count_w'(rd_addr_log[e].size() - base_rd[e]));
        compare_count($sformatf("host_req[%0d].wr strobes", e), j.lines,
                      count_w'(wr_addr_log[e].size() - base_wr[e]));
        for (int i = 0; i < int'(j.lines); i++)
        begin
            word = fill_word(e, j.src + 32'(i));
            compare_addr($sformatf("host_req[%0d].rd_addr", e), j.src + 32'(i),
                         rd_addr_log[e][base_rd[e] + i]);
            compare_addr($sformatf("host_req[%0d].wr_addr", e), j.dst + 32'(i),
                         wr_addr_log[e][base_wr[e] + i]);
            compare_data($sformatf("host_req[%0d].wr_data", e), word,
                         wr_data_log[e][base_wr[e] + i]);
            sum = sum ^ word;
        end
        exp_st = '{active: 1'b0, reads_done: j.lines, writes_done: j.lines, checksum: sum};
        read_status(e, act_st);
        compare_status($sformatf("eng_status[%0d]", e), exp_st, act_st);
    endtask

    // ============================================================
    // Test sequence
    // ============================================================

    initial
    begin
        logic [data_w-1:0] d;
        eng_status_t       st;
        int                i;

        mmio_req = '0;
        rst_n    = 1'b0;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;

        // Identifier, engine count and idle engines straight after reset
        mmio_read(int'(csr_win_global), 0, d);
        compare_data("global id low", afu_test_id[63:0], d);
        mmio_read(int'(csr_win_global), 1, d);
        compare_data("global id high", afu_test_id[127:64], d);
        mmio_read(int'(csr_win_global), 2, d);
        compare_data("global engine count", data_w'(num_engines), d);
        for (int e = 0; e < num_engines; e++)
        begin
            read_status(e, st);
            compare_status($sformatf("eng_status[%0d] after reset", e), '0, st);
            compare_count("host strobes after reset", '0,
                          count_w'(rd_addr_log[e].size() + wr_addr_log[e].size()));
        end

        // Both engines are written first, so crosstalk would show on readback
        for (int e = 0; e < num_engines; e++)
        begin
            mmio_write(e + 1, int'(csr_src_addr), data_w'(32'h0a5c_1000 + 32'(e)));
            mmio_write(e + 1, int'(csr_dst_addr), data_w'(32'hf00d_8000 + 32'(e)));
            mmio_write(e + 1, int'(csr_num_lines), data_w'(16'h1234 + 16'(e)));
        end
        for (int e = 0; e < num_engines; e++)
        begin
            mmio_read(e + 1, int'(csr_src_addr), d);
            compare_data("cfg src_addr", data_w'(32'h0a5c_1000 + 32'(e)), d);
            mmio_read(e + 1, int'(csr_dst_addr), d);
            compare_data("cfg dst_addr", data_w'(32'hf00d_8000 + 32'(e)), d);
            mmio_read(e + 1, int'(csr_num_lines), d);
            compare_data("cfg num_lines", data_w'(16'h1234 + 16'(e)), d);
            mmio_read(e + 1, int'(csr_start), d);
            compare_data("cfg start", '0, d);
        end
        mmio_read(num_engines + 1, 0, d);
        compare_data("unused window", '0, d);
        mmio_read(31, 7, d);
        compare_data("last window", '0, d);

        i = 0;
        while (i < $size(jobs))
        begin
            if (jobs[i].kind == job_pair)
            begin
                program_job(jobs[i]);
                program_job(jobs[i + 1]);
                mmio_write(int'(jobs[i].eng) + 1, int'(csr_start), '0);
                mmio_write(int'(jobs[i + 1].eng) + 1, int'(csr_start), '0);
                // Both engines must be busy together
                mmio_read(int'(jobs[i].eng) + 1, int'(csr_status), d);
                compare_data("first engine active", 64'd1, d);
                mmio_read(int'(jobs[i + 1].eng) + 1, int'(csr_status), d);
                compare_data("second engine active", 64'd1, d);
                wait_idle(int'(jobs[i].eng));
                wait_idle(int'(jobs[i + 1].eng));
                check_job(jobs[i]);
                check_job(jobs[i + 1]);
                i += 2;
            end
            else
            begin
                program_job(jobs[i]);
                mmio_write(int'(jobs[i].eng) + 1, int'(csr_start), '0);
                // A start that lands while the job runs is dropped
                if (jobs[i].kind == job_restart)
                begin
                    mmio_write(int'(jobs[i].eng) + 1, int'(csr_start), '0);
                end
                wait_idle(int'(jobs[i].eng));
                check_job(jobs[i]);
                i += 1;
            end
        end

        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
hw/afu_pkg.sv
hw/csr_mgr.sv
hw/host_mem_rdwr_engine.sv
hw/afu_top.sv
sim/host_mem_model.sv
sim/afu_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --timescale 1ns/1ps -f build.f --top-module afu_tb -o afu_sim \
    && ./obj_dir/afu_sim 2>&1 | tee sim.log \
    || { echo "Build or simulation error"; exit 1; }

grep -q "^TEST PASSED$" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
